// ==== verilog/dma_ctrl_pkg.sv ====
/*
 * DMA control block shared definitions: bus widths, register map,
 * register bus channels, descriptor and status records
 */
`default_nettype none

package dma_ctrl_pkg;

    localparam int REG_ADDR_WIDTH   = 32;
    localparam int REG_DATA_WIDTH   = 32;
    localparam int REG_STRB_WIDTH   = REG_DATA_WIDTH / 8;
    localparam int HOST_ADDR_WIDTH  = 64;
    localparam int LOCAL_ADDR_WIDTH = 32;
    localparam int LEN_WIDTH        = 16;
    localparam int TAG_WIDTH        = 8;
    localparam int STATUS_VALID_BIT = 31;

    // register map, byte offsets within BAR 0
    localparam logic [15:0] REG_DMA_ENABLE  = 16'h0000;
    localparam logic [15:0] REG_RD_HOST_LO  = 16'h0100;
    localparam logic [15:0] REG_RD_HOST_HI  = 16'h0104;
    localparam logic [15:0] REG_RD_LOCAL    = 16'h0108;
    localparam logic [15:0] REG_RD_LEN      = 16'h0110;
    localparam logic [15:0] REG_RD_TAG      = 16'h0114;
    localparam logic [15:0] REG_RD_STATUS   = 16'h0118;
    localparam logic [15:0] REG_WR_HOST_LO  = 16'h0200;
    localparam logic [15:0] REG_WR_HOST_HI  = 16'h0204;
    localparam logic [15:0] REG_WR_LOCAL    = 16'h0208;
    localparam logic [15:0] REG_WR_LEN      = 16'h0210;
    localparam logic [15:0] REG_WR_TAG      = 16'h0214;
    localparam logic [15:0] REG_WR_STATUS   = 16'h0218;
    localparam logic [15:0] REG_CNT_RQ      = 16'h0400;
    localparam logic [15:0] REG_CNT_RC      = 16'h0404;
    localparam logic [15:0] REG_CNT_CQ      = 16'h0408;
    localparam logic [15:0] REG_CNT_CC      = 16'h040C;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] awaddr;
        logic                      awvalid;
        logic [REG_DATA_WIDTH-1:0] wdata;
        logic [REG_STRB_WIDTH-1:0] wstrb;
        logic                      wvalid;
        logic                      bready;
        logic [REG_ADDR_WIDTH-1:0] araddr;
        logic                      arvalid;
        logic                      rready;
    } reg_req_t;

    typedef struct packed {
        logic                      awready;
        logic                      wready;
        logic [1:0]                bresp;
        logic                      bvalid;
        logic                      arready;
        logic [REG_DATA_WIDTH-1:0] rdata;
        logic [1:0]                rresp;
        logic                      rvalid;
    } reg_rsp_t;

    typedef struct packed {
        logic [HOST_ADDR_WIDTH-1:0]  host_addr;
        logic [LOCAL_ADDR_WIDTH-1:0] local_addr;
        logic [LEN_WIDTH-1:0]        len;
        logic [TAG_WIDTH-1:0]        tag;
    } dma_desc_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic                 valid;
    } desc_status_t;

    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } stream_mon_t;

    typedef enum logic [2:0] {
        HOST_LO,
        HOST_HI,
        LOCAL,
        LEN,
        TAG
    } desc_field_e;

    typedef struct packed {
        logic                      en;
        desc_field_e               field;
        logic [REG_DATA_WIDTH-1:0] data;
    } chan_wr_t;

endpackage

`default_nettype wire

// ==== verilog/ctrl_reg_access.sv ====
/*
 * Register bus front end that accepts single-beat reads and writes,
 * decodes the register map and returns held responses
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_reg_access import dma_ctrl_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire reg_req_t                  reg_req,
    output reg_rsp_t                       reg_rsp,
    output chan_wr_t                       rd_chan_wr,
    output chan_wr_t                       wr_chan_wr,
    output logic                           rd_status_pop,
    output logic                           wr_status_pop,
    input  wire logic [REG_DATA_WIDTH-1:0] rd_status_word,
    input  wire logic [REG_DATA_WIDTH-1:0] wr_status_word,
    input  wire logic [REG_DATA_WIDTH-1:0] cnt_rq,
    input  wire logic [REG_DATA_WIDTH-1:0] cnt_rc,
    input  wire logic [REG_DATA_WIDTH-1:0] cnt_cq,
    input  wire logic [REG_DATA_WIDTH-1:0] cnt_cc,
    output logic                           dma_enable
);

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

    wr_state_t                 wr_state;
    rd_state_t                 rd_state;
    logic                      wr_take;
    logic                      rd_take;
    logic [15:0]               wr_off;
    logic [15:0]               rd_off;
    logic                      enable_wr;
    logic                      awready_q;
    logic                      wready_q;
    logic                      arready_q;
    logic [REG_DATA_WIDTH-1:0] rd_mux;
    logic [REG_DATA_WIDTH-1:0] rdata_q;

    // word aligned offsets within the BAR
    assign wr_off = {reg_req.awaddr[15:2], 2'b00};
    assign rd_off = {reg_req.araddr[15:2], 2'b00};

    assign wr_take = reg_req.awvalid && reg_req.wvalid && (wr_state == WR_IDLE);
    assign rd_take = reg_req.arvalid && (rd_state == RD_IDLE);

    // write decode into channel field strobes
    always_comb begin
        rd_chan_wr.en    = 1'b0;
        rd_chan_wr.field = HOST_LO;
        rd_chan_wr.data  = reg_req.wdata;
        wr_chan_wr.en    = 1'b0;
        wr_chan_wr.field = HOST_LO;
        wr_chan_wr.data  = reg_req.wdata;
        enable_wr        = 1'b0;
        if (wr_take) begin
            case (wr_off)
                REG_DMA_ENABLE: enable_wr = 1'b1;
                REG_RD_HOST_LO: {rd_chan_wr.en, rd_chan_wr.field} = {1'b1, HOST_LO};
                REG_RD_HOST_HI: {rd_chan_wr.en, rd_chan_wr.field} = {1'b1, HOST_HI};
                REG_RD_LOCAL:   {rd_chan_wr.en, rd_chan_wr.field} = {1'b1, LOCAL};
                REG_RD_LEN:     {rd_chan_wr.en, rd_chan_wr.field} = {1'b1, LEN};
                REG_RD_TAG:     {rd_chan_wr.en, rd_chan_wr.field} = {1'b1, TAG};
                REG_WR_HOST_LO: {wr_chan_wr.en, wr_chan_wr.field} = {1'b1, HOST_LO};
                REG_WR_HOST_HI: {wr_chan_wr.en, wr_chan_wr.field} = {1'b1, HOST_HI};
                REG_WR_LOCAL:   {wr_chan_wr.en, wr_chan_wr.field} = {1'b1, LOCAL};
                REG_WR_LEN:     {wr_chan_wr.en, wr_chan_wr.field} = {1'b1, LEN};
                REG_WR_TAG:     {wr_chan_wr.en, wr_chan_wr.field} = {1'b1, TAG};
                default: ;
            endcase
        end
    end

    // read mux with unmapped offsets reading as zero
    always_comb begin
        rd_mux = '0;
        case (rd_off)
            REG_DMA_ENABLE: rd_mux[0] = dma_enable;
            REG_RD_STATUS:  rd_mux = rd_status_word;
            REG_WR_STATUS:  rd_mux = wr_status_word;
            REG_CNT_RQ:     rd_mux = cnt_rq;
            REG_CNT_RC:     rd_mux = cnt_rc;
            REG_CNT_CQ:     rd_mux = cnt_cq;
            REG_CNT_CC:     rd_mux = cnt_cc;
            default: ;
        endcase
    end

    // status pops only when a status register read is taken
    assign rd_status_pop = rd_take && (rd_off == REG_RD_STATUS);
    assign wr_status_pop = rd_take && (rd_off == REG_WR_STATUS);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state   <= WR_IDLE;
            rd_state   <= RD_IDLE;
            awready_q  <= 1'b0;
            wready_q   <= 1'b0;
            arready_q  <= 1'b0;
            dma_enable <= 1'b0;
        end else begin
            awready_q <= wr_take;
            wready_q  <= wr_take;
            arready_q <= rd_take;
            if (enable_wr) begin
                dma_enable <= reg_req.wdata[0];
            end
            case (wr_state)
                WR_IDLE: if (wr_take) wr_state <= WR_RESP;
                WR_RESP: if (reg_req.bready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
            case (rd_state)
                RD_IDLE: if (rd_take) rd_state <= RD_RESP;
                RD_RESP: if (reg_req.rready) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // held until the requester takes it
    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        reg_rsp.awready = awready_q;
        reg_rsp.wready  = wready_q;
        reg_rsp.bresp   = 2'b00;
        reg_rsp.bvalid  = (wr_state == WR_RESP);
        reg_rsp.arready = arready_q;
        reg_rsp.rdata   = rdata_q;
        reg_rsp.rresp   = 2'b00;
        reg_rsp.rvalid  = (rd_state == RD_RESP);
    end

endmodule

`default_nettype wire

// ==== verilog/desc_channel.sv ====
/*
 * One DMA descriptor channel with descriptor field registers, launch
 * on tag write, completion status word and status pop
 */
`timescale 1ns/1ps
`default_nettype none

module desc_channel import dma_ctrl_pkg::*; (
    input  wire logic                       clk,
    input  wire logic                       rst,

    // field writes from the register front end
    input  wire chan_wr_t                   chan_wr,
    input  wire logic                       status_pop,

    // descriptor towards the DMA engine
    output dma_desc_t                       desc,
    output logic                            desc_valid,
    input  wire logic                       desc_ready,

    // completion status from the DMA engine
    input  wire desc_status_t               status,
    output logic                            status_ready,

    output logic [REG_DATA_WIDTH-1:0]       status_word
);

    logic tag_wr;

    assign tag_wr = chan_wr.en && (chan_wr.field == TAG);

    // descriptor fields
    always_ff @(posedge clk) begin
        if (chan_wr.en) begin
            case (chan_wr.field)
                HOST_LO: begin
                    desc.host_addr[31:0] <= chan_wr.data;
                end
                HOST_HI: begin
                    desc.host_addr[HOST_ADDR_WIDTH-1:32] <= chan_wr.data;
                end
                LOCAL: begin
                    desc.local_addr <= chan_wr.data[LOCAL_ADDR_WIDTH-1:0];
                end
                LEN: begin
                    desc.len <= chan_wr.data[LEN_WIDTH-1:0];
                end
                TAG: begin
                    desc.tag <= chan_wr.data[TAG_WIDTH-1:0];
                end
                default: ;
            endcase
        end
    end

    // a tag write launches and also relaunches with new fields
    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid <= 1'b0;
        end else if (tag_wr) begin
            desc_valid <= 1'b1;
        end else if (desc_ready) begin
            desc_valid <= 1'b0;
        end
    end

    // pop only what is actually pending
    always_ff @(posedge clk) begin
        if (rst) begin
            status_ready <= 1'b0;
        end else begin
            status_ready <= status_pop && status.valid;
        end
    end

    // tag in the low byte and pending flag on top
    always_comb begin
        status_word                   = '0;
        status_word[TAG_WIDTH-1:0]    = status.tag;
        status_word[STATUS_VALID_BIT] = status.valid;
    end

endmodule

`default_nettype wire

// ==== verilog/xfer_counters.sv ====
/*
 * Wrapping packet counters for the four PCIe streams that count
 * one per accepted last beat
 */
`timescale 1ns/1ps
`default_nettype none

module xfer_counters import dma_ctrl_pkg::*; #(
    parameter int COUNT_WIDTH = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire stream_mon_t       mon_rq,
    input  wire stream_mon_t       mon_rc,
    input  wire stream_mon_t       mon_cq,
    input  wire stream_mon_t       mon_cc,
    output logic [COUNT_WIDTH-1:0] cnt_rq,
    output logic [COUNT_WIDTH-1:0] cnt_rc,
    output logic [COUNT_WIDTH-1:0] cnt_cq,
    output logic [COUNT_WIDTH-1:0] cnt_cc
);

    stream_mon_t            mon [4];
    logic [COUNT_WIDTH-1:0] cnt [4];

    assign mon[0] = mon_rq;
    assign mon[1] = mon_rc;
    assign mon[2] = mon_cq;
    assign mon[3] = mon_cc;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                cnt[i] <= '0;
            end else if (mon[i].valid && mon[i].ready && mon[i].last) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign cnt_rq = cnt[0];
    assign cnt_rc = cnt[1];
    assign cnt_cq = cnt[2];
    assign cnt_cc = cnt[3];

endmodule

`default_nettype wire

// ==== verilog/dma_ctrl_top.sv ====
/*
 * DMA control register block behind BAR 0 with register bus access,
 * read and write descriptor channels, stream counters and interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_top import dma_ctrl_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,

    // register bus
    input  wire reg_req_t     reg_req,
    output reg_rsp_t          reg_rsp,

    // descriptors to the DMA engine
    output dma_desc_t         rd_desc,
    output logic              rd_desc_valid,
    input  wire logic         rd_desc_ready,
    output dma_desc_t         wr_desc,
    output logic              wr_desc_valid,
    input  wire logic         wr_desc_ready,

    // completion status from the DMA engine
    input  wire desc_status_t rd_status,
    output logic              rd_status_ready,
    input  wire desc_status_t wr_status,
    output logic              wr_status_ready,

    output logic              dma_enable,

    // stream monitors
    input  wire stream_mon_t  mon_rq,
    input  wire stream_mon_t  mon_rc,
    input  wire stream_mon_t  mon_cq,
    input  wire stream_mon_t  mon_cc,

    output logic              irq
);

    localparam int COUNT_WIDTH = REG_DATA_WIDTH;

    chan_wr_t                  rd_chan_wr;
    chan_wr_t                  wr_chan_wr;
    logic                      rd_status_pop;
    logic                      wr_status_pop;
    logic [REG_DATA_WIDTH-1:0] rd_status_word;
    logic [REG_DATA_WIDTH-1:0] wr_status_word;
    logic [COUNT_WIDTH-1:0]    cnt_rq;
    logic [COUNT_WIDTH-1:0]    cnt_rc;
    logic [COUNT_WIDTH-1:0]    cnt_cq;
    logic [COUNT_WIDTH-1:0]    cnt_cc;

    ctrl_reg_access access_i (
        .clk            (clk),
        .rst            (rst),
        .reg_req        (reg_req),
        .reg_rsp        (reg_rsp),
        .rd_chan_wr     (rd_chan_wr),
        .wr_chan_wr     (wr_chan_wr),
        .rd_status_pop  (rd_status_pop),
        .wr_status_pop  (wr_status_pop),
        .rd_status_word (rd_status_word),
        .wr_status_word (wr_status_word),
        .cnt_rq         (cnt_rq),
        .cnt_rc         (cnt_rc),
        .cnt_cq         (cnt_cq),
        .cnt_cc         (cnt_cc),
        .dma_enable     (dma_enable)
    );

    desc_channel rd_chan_i (
        .clk          (clk),
        .rst          (rst),
        .chan_wr      (rd_chan_wr),
        .status_pop   (rd_status_pop),
        .desc         (rd_desc),
        .desc_valid   (rd_desc_valid),
        .desc_ready   (rd_desc_ready),
        .status       (rd_status),
        .status_ready (rd_status_ready),
        .status_word  (rd_status_word)
    );

    desc_channel wr_chan_i (
        .clk          (clk),
        .rst          (rst),
        .chan_wr      (wr_chan_wr),
        .status_pop   (wr_status_pop),
        .desc         (wr_desc),
        .desc_valid   (wr_desc_valid),
        .desc_ready   (wr_desc_ready),
        .status       (wr_status),
        .status_ready (wr_status_ready),
        .status_word  (wr_status_word)
    );

    xfer_counters #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) counters_i (
        .clk    (clk),
        .rst    (rst),
        .mon_rq (mon_rq),
        .mon_rc (mon_rc),
        .mon_cq (mon_cq),
        .mon_cc (mon_cc),
        .cnt_rq (cnt_rq),
        .cnt_rc (cnt_rc),
        .cnt_cq (cnt_cq),
        .cnt_cc (cnt_cc)
    );

    // level interrupt while any completion is pending
    assign irq = rd_status.valid || wr_status.valid;

endmodule

`default_nettype wire

// ==== testbench/dma_ctrl_model.svh ====
/*
 * Reference model of the DMA control block: enable bit, descriptor
 * channels and stream packet counts, updated once per clock edge
 */
`ifndef DMA_CTRL_MODEL_SVH
`define DMA_CTRL_MODEL_SVH

logic        m_enable;
logic [63:0] m_host [2];
logic [31:0] m_local [2];
logic [15:0] m_len [2];
logic [7:0]  m_tag [2];
logic        m_valid [2];
logic [31:0] m_cnt [4];

function automatic void model_reset();
    m_enable = 1'b0;
    for (int ch = 0; ch < 2; ch++) begin
        m_host[ch]  = '0;
        m_local[ch] = '0;
        m_len[ch]   = '0;
        m_tag[ch]   = '0;
        m_valid[ch] = 1'b0;
    end
    for (int i = 0; i < 4; i++) begin
        m_cnt[i] = '0;
    end
endfunction

// one clock edge: an optional register write, descriptor readies, stream beats
function automatic void model_edge(input logic wr_taken, input logic [15:0] off,
                                   input logic [31:0] data, input logic [1:0] desc_rdy,
                                   input logic [3:0] fire);
    logic [1:0]  tag_wr;
    logic [15:0] rel;
    tag_wr = 2'b00;
    if (wr_taken) begin
        if (off == REG_DMA_ENABLE) begin
            m_enable = data[0];
        end
        // write channel sits 0x100 above the read channel
        for (int ch = 0; ch < 2; ch++) begin
            rel = (ch == 0) ? off : off - 16'h0100;
            case (rel)
                REG_RD_HOST_LO: m_host[ch][31:0]  = data;
                REG_RD_HOST_HI: m_host[ch][63:32] = data;
                REG_RD_LOCAL:   m_local[ch]       = data;
                REG_RD_LEN:     m_len[ch]         = data[15:0];
                REG_RD_TAG: begin
                    m_tag[ch]  = data[7:0];
                    tag_wr[ch] = 1'b1;
                end
                default: ;
            endcase
        end
    end
    for (int ch = 0; ch < 2; ch++) begin
        if (tag_wr[ch]) begin
            m_valid[ch] = 1'b1;
        end else if (desc_rdy[ch]) begin
            m_valid[ch] = 1'b0;
        end
    end
    for (int i = 0; i < 4; i++) begin
        if (fire[i]) begin
            m_cnt[i] = m_cnt[i] + 1;
        end
    end
endfunction

// expected read data for a read taken while these status inputs are present
function automatic logic [31:0] model_read(input logic [15:0] off,
                                           input desc_status_t st_rd,
                                           input desc_status_t st_wr);
    logic [31:0] v;
    v = '0;
    case (off)
        REG_DMA_ENABLE: v[0] = m_enable;
        REG_RD_STATUS:  v = {st_rd.valid, 23'd0, st_rd.tag};
        REG_WR_STATUS:  v = {st_wr.valid, 23'd0, st_wr.tag};
        REG_CNT_RQ:     v = m_cnt[0];
        REG_CNT_RC:     v = m_cnt[1];
        REG_CNT_CQ:     v = m_cnt[2];
        REG_CNT_CC:     v = m_cnt[3];
        default: ;
    endcase
    return v;
endfunction

`endif

// ==== testbench/tb_dma_ctrl.sv ====
/*
 * Testbench for the DMA control register block with random register
 * bus traffic and background stream activity checked against a model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dma_ctrl import dma_ctrl_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_OPS    = 400;

    logic         clk;
    logic         rst;
    reg_req_t     req;
    reg_rsp_t     rsp;
    dma_desc_t    rd_desc;
    logic         rd_desc_valid;
    logic         rd_desc_ready;
    dma_desc_t    wr_desc;
    logic         wr_desc_valid;
    logic         wr_desc_ready;
    desc_status_t rd_status;
    logic         rd_status_ready;
    desc_status_t wr_status;
    logic         wr_status_ready;
    logic         dma_enable;
    stream_mon_t  mon_rq;
    stream_mon_t  mon_rc;
    stream_mon_t  mon_cq;
    stream_mon_t  mon_cc;
    logic         irq;

    integer       seed;
    logic [15:0]  wr_off_cur;
    logic [31:0]  wr_data_cur;
    logic [15:0]  rd_off_cur;
    logic [31:0]  exp_rdata;

    `include "dma_ctrl_model.svh"

    dma_ctrl_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .reg_req         (req),
        .reg_rsp         (rsp),
        .rd_desc         (rd_desc),
        .rd_desc_valid   (rd_desc_valid),
        .rd_desc_ready   (rd_desc_ready),
        .wr_desc         (wr_desc),
        .wr_desc_valid   (wr_desc_valid),
        .wr_desc_ready   (wr_desc_ready),
        .rd_status       (rd_status),
        .rd_status_ready (rd_status_ready),
        .wr_status       (wr_status),
        .wr_status_ready (wr_status_ready),
        .dma_enable      (dma_enable),
        .mon_rq          (mon_rq),
        .mon_rc          (mon_rc),
        .mon_cq          (mon_cq),
        .mon_cc          (mon_cc),
        .irq             (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_desc(input dma_desc_t d, input logic v, input int ch);
        check_val(v, m_valid[ch], $sformatf("channel %0d descriptor valid", ch));
        if (m_valid[ch]) begin
            check_val(d.host_addr, m_host[ch], $sformatf("channel %0d host address", ch));
            check_val(d.local_addr, m_local[ch], $sformatf("channel %0d local address", ch));
            check_val(d.len, m_len[ch], $sformatf("channel %0d length", ch));
            check_val(d.tag, m_tag[ch], $sformatf("channel %0d tag", ch));
        end
    endtask

    function automatic logic fired(input stream_mon_t m);
        return m.valid && m.ready && m.last;
    endfunction

    task automatic drive_background();
        logic [31:0] r;
        r = $random(seed);
        rd_desc_ready   = r[0];
        wr_desc_ready   = r[1];
        rd_status.valid = r[2];
        wr_status.valid = r[3];
        rd_status.tag   = r[11:4];
        wr_status.tag   = r[19:12];
        mon_rq          = r[22:20];
        mon_rc          = r[25:23];
        mon_cq          = r[28:26];
        mon_cc          = r[31:29];
    endtask

    // advances one clock and returns 1 ns after the rising edge
    task automatic step();
        desc_status_t st_rd;
        desc_status_t st_wr;
        logic [1:0]   rdy;
        logic [3:0]   fire;
        logic         rd_taken;
        #1;
        check_val(irq, rd_status.valid | wr_status.valid, "irq level");
        @(posedge clk);
        st_rd = rd_status;
        st_wr = wr_status;
        rdy   = {wr_desc_ready, rd_desc_ready};
        fire  = {fired(mon_cc), fired(mon_cq), fired(mon_rc), fired(mon_rq)};
        #1;
        rd_taken = rsp.arready;
        if (rd_taken) begin
            exp_rdata = model_read(rd_off_cur, st_rd, st_wr);
        end
        check_val(rd_status_ready, rd_taken && rd_off_cur == REG_RD_STATUS && st_rd.valid,
                  "read channel status ready");
        check_val(wr_status_ready, rd_taken && rd_off_cur == REG_WR_STATUS && st_wr.valid,
                  "write channel status ready");
        model_edge(rsp.awready, wr_off_cur, wr_data_cur, rdy, fire);
        check_val(dma_enable, m_enable, "dma enable");
        check_desc(rd_desc, rd_desc_valid, 0);
        check_desc(wr_desc, wr_desc_valid, 1);
        drive_background();
    endtask

    task automatic write_reg(input logic [15:0] off, input logic [31:0] data);
        logic [31:0] r;
        int          stall;
        wr_off_cur  = off;
        wr_data_cur = data;
        req.awaddr  = {16'h0000, off};
        req.wdata   = data;
        req.wstrb   = 4'hF;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        do begin
            step();
        end while (!rsp.awready);
        check_val(rsp.wready, 1'b1, "write ready with address ready");
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        r = $random(seed);
        stall = 1 + r[1:0];
        // response ready held low for a while
        for (int i = 0; i < stall; i++) begin
            check_val(rsp.bvalid, 1'b1, "write response valid");
            check_val(rsp.bresp, 2'b00, "write response code");
            step();
            if (i == 0) begin
                check_val({rsp.awready, rsp.wready}, 2'b00, "write ready pulse length");
            end
        end
        check_val(rsp.bvalid, 1'b1, "write response valid");
        req.bready = 1'b1;
        step();
        req.bready = 1'b0;
        check_val(rsp.bvalid, 1'b0, "write response cleared");
    endtask

    task automatic read_reg(input logic [15:0] off, output logic [31:0] data);
        logic [31:0] r;
        int          stall;
        rd_off_cur  = off;
        req.araddr  = {16'h0000, off};
        req.arvalid = 1'b1;
        do begin
            step();
        end while (!rsp.arready);
        req.arvalid = 1'b0;
        r = $random(seed);
        stall = 1 + r[1:0];
        // data must hold while read ready stays low
        for (int i = 0; i < stall; i++) begin
            check_val(rsp.rvalid, 1'b1, "read valid");
            check_val(rsp.rdata, exp_rdata, $sformatf("read data at offset %h", off));
            check_val(rsp.rresp, 2'b00, "read response code");
            step();
            if (i == 0) begin
                check_val(rsp.arready, 1'b0, "read address ready pulse length");
            end
        end
        check_val(rsp.rvalid, 1'b1, "read valid");
        check_val(rsp.rdata, exp_rdata, $sformatf("read data at offset %h", off));
        data = rsp.rdata;
        req.rready = 1'b1;
        step();
        req.rready = 1'b0;
        check_val(rsp.rvalid, 1'b0, "read response cleared");
    endtask

    initial begin
        #(NUM_OPS * 64 * CLK_PERIOD);
        $display("timeout: the register bus operations did not complete in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] got;
        logic [15:0] base;
        logic [15:0] off;
        seed          = 61;
        rst           = 1'b1;
        req           = '0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status     = '0;
        wr_status     = '0;
        mon_rq        = '0;
        mon_rc        = '0;
        mon_cq        = '0;
        mon_cc        = '0;
        wr_off_cur    = '0;
        wr_data_cur   = '0;
        rd_off_cur    = '0;
        exp_rdata     = '0;
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_val({rsp.awready, rsp.wready, rsp.bvalid, rsp.arready, rsp.rvalid}, 5'd0,
                  "bus outputs after reset");
        check_val({rd_desc_valid, wr_desc_valid, rd_status_ready, wr_status_ready, dma_enable},
                  5'd0, "control outputs after reset");

        for (int op = 0; op < NUM_OPS; op++) begin
            r = $random(seed);
            case (r % 5)
                0: begin
                    data = $random(seed);
                    write_reg(REG_DMA_ENABLE, data);
                    read_reg(REG_DMA_ENABLE, got);
                    check_val(got, {31'd0, data[0]}, "enable readback");
                end
                1: begin
                    base = r[3] ? 16'h0100 : 16'h0000;
                    write_reg(REG_RD_HOST_LO + base, $random(seed));
                    write_reg(REG_RD_HOST_HI + base, $random(seed));
                    write_reg(REG_RD_LOCAL + base, $random(seed));
                    write_reg(REG_RD_LEN + base, $random(seed));
                    write_reg(REG_RD_TAG + base, $random(seed));
                end
                2: read_reg(r[3] ? REG_WR_STATUS : REG_RD_STATUS, got);
                3: read_reg(REG_CNT_RQ + {12'd0, r[4:3], 2'b00}, got);
                default: begin
                    // hole between the channel and counter blocks
                    off = 16'h0300 | {8'd0, r[10:5], 2'b00};
                    write_reg(off, $random(seed));
                    read_reg(off, got);
                    read_reg(REG_DMA_ENABLE, got);
                end
            endcase
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+testbench
verilog/dma_ctrl_pkg.sv
verilog/ctrl_reg_access.sv
verilog/desc_channel.sv
verilog/xfer_counters.sv
verilog/dma_ctrl_top.sv
testbench/tb_dma_ctrl.sv
